/* dv/tb_tcdm_bank.sv */
// Testbench for the TCDM bank top level.
// Only words 0 to 15 are used, all written before the first load.
// Runs init stores, store/load pairs and atomics, then a random mix
// with random response back-pressure. Latency is checked while out_ready_i is high.
`timescale 1ns/1ps

module tb_tcdm_bank
  import tcdm_pkg::*;
  import amo_pkg::*;
();

  localparam int unsigned NumRequests   = 16 + 40 + 90 + 200;
  localparam int unsigned TimeoutCycles = 20 * NumRequests;

  // Expected response with its acceptance cycle
  typedef struct packed {
    data_t       rdata;
    meta_t       meta;
    logic [31:0] acc_cycle;
    logic        chk_lat;
  } exp_rsp_t;

  logic      clk_i;
  logic      rst_ni;
  logic      in_valid_i;
  tcdm_req_t req_i;
  logic      in_ready_o;
  logic      out_valid_o;
  logic      out_ready_i;
  tcdm_rsp_t rsp_o;

  logic [31:0] lfsr_q = 32'h3027e2fd;
  logic [31:0] cycle_cnt = '0;
  meta_t       meta_ctr = '0;
  logic        ready_rand = 1'b0;
  logic        ready_pat [TimeoutCycles+1];
  data_t       ref_mem [BankWords];
  exp_rsp_t    exp_q [$];

  int unsigned rdata_errs = 0;
  int unsigned meta_errs = 0;
  int unsigned lat_errs = 0;
  int unsigned other_errs = 0;
  int unsigned rsp_cnt = 0;

  tcdm_bank_top tcdm_bank_top_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i),
    .req_i       (req_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .rsp_o       (rsp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ------------------------------
  // Random source
  // ------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic data_t ref_amo(input amo_op_e op, input data_t old, input data_t opnd);
    case (op)
      AmoSwap: return opnd;
      AmoAdd:  return old + opnd;
      AmoAnd:  return old & opnd;
      AmoOr:   return old | opnd;
      AmoXor:  return old ^ opnd;
      AmoMax:  return ($signed(old) > $signed(opnd)) ? old : opnd;
      AmoMaxu: return (old > opnd) ? old : opnd;
      AmoMin:  return ($signed(old) < $signed(opnd)) ? old : opnd;
      AmoMinu: return (old < opnd) ? old : opnd;
      default: return old;
    endcase
  endfunction

  // Applied in acceptance order
  always @(posedge clk_i) begin
    if (rst_ni && in_valid_i && in_ready_o) begin
      apply_req(req_i);
    end
  end

  task automatic apply_req(input tcdm_req_t r);
    bank_idx_t idx;
    data_t     old;
    logic      atomic;
    exp_rsp_t  e;
    idx    = r.addr[ByteOffWidth +: BankIdxWidth];
    old    = ref_mem[idx];
    atomic = (r.amo >= 4'd1) && (r.amo <= 4'd9);
    if (atomic || !r.write) begin
      e.rdata     = old;
      e.meta      = r.meta;
      e.acc_cycle = cycle_cnt;
      e.chk_lat   = !ready_rand;
      exp_q.push_back(e);
    end
    if (atomic) begin
      ref_mem[idx] = ref_amo(amo_op_e'(r.amo), old, r.wdata);
    end else if (r.write) begin
      for (int b = 0; b < BeWidth; b++) begin
        if (r.be[b]) begin
          ref_mem[idx][b*8 +: 8] = r.wdata[b*8 +: 8];
        end
      end
    end
  endtask

  // ------------------------------
  // Response comparison
  // ------------------------------
  always @(posedge clk_i) begin
    exp_rsp_t e;
    if (rst_ni && out_valid_o && out_ready_i) begin
      rsp_cnt++;
      if (exp_q.size() == 0) begin
        other_errs++;
        $display("ERROR %0t: response delivered with no request outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        if (rsp_o.rdata !== e.rdata) begin
          rdata_errs++;
          $display("ERROR %0t: rsp_o.rdata expected %h actual %h", $time, e.rdata, rsp_o.rdata);
        end
        if (rsp_o.meta !== e.meta) begin
          meta_errs++;
          $display("ERROR %0t: rsp_o.meta expected %h actual %h", $time, e.meta, rsp_o.meta);
        end
        if (e.chk_lat && (cycle_cnt != e.acc_cycle + 1)) begin
          lat_errs++;
          $display("ERROR %0t: out_valid_o cycle expected %0d actual %0d",
                   $time, e.acc_cycle + 1, cycle_cnt);
        end
      end
    end
  end

  // Response back-pressure is held high outside the random phase
  always @(posedge clk_i) begin
    out_ready_i <= ready_rand ? ready_pat[cycle_cnt] : 1'b1;
  end

  // Cycle count and run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: run still busy after %0d cycles", cycle_cnt);
      report_and_finish(1'b1);
    end
  end

  task automatic report_and_finish(input logic timed_out);
    int unsigned sva_errs;
    sva_errs = tcdm_bank_top_inst.bank_checker_inst.assert_fails;
    $display("Errors: rdata %0d, meta %0d, latency %0d, assertion %0d, other %0d (%0d responses)",
             rdata_errs, meta_errs, lat_errs, sva_errs, other_errs, rsp_cnt);
    if (timed_out || (rdata_errs + meta_errs + lat_errs + sva_errs + other_errs != 0)) begin
      $display("FAIL: see errors above");
    end else begin
      $display("PASS: all tests");
    end
    $finish;
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  function automatic tcdm_req_t build_req(input logic [3:0] word, input logic [3:0] code,
                                          input logic wr, input data_t wdata, input be_t be);
    tcdm_req_t r;
    r.addr  = addr_t'(word) << ByteOffWidth;
    r.amo   = code;
    r.write = wr;
    r.wdata = wdata;
    r.be    = be;
    r.meta  = meta_ctr;
    meta_ctr++;
    return r;
  endfunction

  // Valid stays up until the handshake edge
  task automatic send_req(input tcdm_req_t r);
    in_valid_i <= 1'b1;
    req_i      <= r;
    do @(posedge clk_i); while (!in_ready_o);
    in_valid_i <= 1'b0;
  endtask

  task automatic drain();
    @(posedge clk_i);
    while (exp_q.size() != 0) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
  endtask

  initial begin
    logic [3:0] idx;
    logic [3:0] code;
    data_t      opnd;
    data_t      old;
    rst_ni      = 1'b0;
    in_valid_i  = 1'b0;
    req_i       = '0;
    out_ready_i = 1'b1;
    for (int i = 0; i <= TimeoutCycles; i++) begin
      ready_pat[i] = rand_bits(1);
    end
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    if (out_valid_o !== 1'b0) begin
      other_errs++;
      $display("ERROR %0t: out_valid_o expected 0 actual %b", $time, out_valid_o);
    end
    if (in_ready_o !== 1'b1) begin
      other_errs++;
      $display("ERROR %0t: in_ready_o expected 1 actual %b", $time, in_ready_o);
    end
    // Full-word init of the 16 test words
    for (int i = 0; i < 16; i++) begin
      send_req(build_req(4'(i), AmoNone, 1'b1, rand_bits(32), 4'hF));
    end
    // Partial stores each read back
    for (int i = 0; i < 20; i++) begin
      idx = 4'(rand_bits(4));
      send_req(build_req(idx, AmoNone, 1'b1, rand_bits(32), be_t'(rand_bits(4))));
      send_req(build_req(idx, AmoNone, 1'b0, rand_bits(32), be_t'(rand_bits(4))));
    end
    // Every atomic with the first two rounds forcing opposite top bits
    for (int op = 1; op <= 9; op++) begin
      for (int k = 0; k < 4; k++) begin
        idx  = 4'(rand_bits(4));
        opnd = rand_bits(32);
        if (k < 2) begin
          old      = rand_bits(32);
          old[31]  = k[0];
          opnd[31] = ~k[0];
          send_req(build_req(idx, AmoNone, 1'b1, old, 4'hF));
        end
        send_req(build_req(idx, 4'(op), 1'(rand_bits(1)), opnd, be_t'(rand_bits(4))));
        send_req(build_req(idx, AmoNone, 1'b0, '0, 4'hF));
      end
    end
    drain();
    // Random mix under back-pressure where codes 10 to 15 act as plain accesses
    ready_rand <= 1'b1;
    for (int i = 0; i < 200; i++) begin
      idx = 4'(rand_bits(4));
      case (2'(rand_bits(2)))
        2'd0: code = AmoNone;
        2'd1: code = 4'(rand_bits(4) % 9 + 1);
        2'd2: code = 4'(rand_bits(3) % 6 + 10);
        default: code = AmoNone;
      endcase
      send_req(build_req(idx, code, 1'(rand_bits(1)), rand_bits(32), be_t'(rand_bits(4))));
      if (rand_bits(2) == 0) begin
        @(posedge clk_i);
      end
    end
    drain();
    report_and_finish(1'b0);
  end

endmodule

/* dv/tcdm_bank_checker.sv */
// Assertions bound into the TCDM bank top level.
// Checked only while reset is released.
`timescale 1ns/1ps

module tcdm_bank_checker
  import tcdm_pkg::*;
  import amo_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input logic      in_valid_i,
  input tcdm_req_t req_i,
  input logic      in_ready_o,
  input logic      out_valid_o,
  input logic      out_ready_i,
  input tcdm_rsp_t rsp_o
);

  logic amo_accept;

  // Number of assertion failures so far
  int unsigned assert_fails = 0;

  // Handshake on a request with an atomic code
  assign amo_accept = in_valid_i & in_ready_o &
                      (amo_op_e'(req_i.amo) inside {[AmoSwap:AmoMinu]});

  // Response must hold until it is taken
  rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(rsp_o))
    else begin
      $error("response changed or dropped before it was taken");
      assert_fails++;
    end

  // Write-back cycle blocks the request port
  amo_blocks: assert property (@(posedge clk_i) disable iff (!rst_ni)
    amo_accept |=> !in_ready_o)
    else begin
      $error("request port open in the cycle after an atomic");
      assert_fails++;
    end

  // No acceptance while a response waits
  wait_blocks: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |-> !in_ready_o)
    else begin
      $error("request port open while a response waits");
      assert_fails++;
    end

endmodule

bind tcdm_bank_top tcdm_bank_checker bank_checker_inst (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .in_valid_i  (in_valid_i),
  .req_i       (req_i),
  .in_ready_o  (in_ready_o),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .rsp_o       (rsp_o)
);

/* rtl/amo_alu.sv */
// Combinational AMO ALU.
// old_i is the word read from memory, operand_i the request write data.
// One adder serves add and the four min/max compares.
// AmoNone leaves the memory word unchanged.
`timescale 1ns/1ps

module amo_alu
  import tcdm_pkg::*;
  import amo_pkg::*;
(
  input  amo_op_e op_i,
  input  data_t   old_i,
  input  data_t   operand_i,
  output data_t   result_o
);

  // Two guard bits so the subtraction sign never overflows
  logic [DataWidth+1:0] adder_a;
  logic [DataWidth+1:0] adder_b;
  logic [DataWidth+1:0] adder_sum;
  logic                 do_sub;
  logic                 do_sext;
  logic                 old_lt;

  // ------------------------------
  // Shared adder
  // ------------------------------
  always_comb begin
    do_sub  = op_i inside {AmoMax, AmoMaxu, AmoMin, AmoMinu};
    // Signed compare needs sign extension, unsigned gets zeros
    do_sext = op_i inside {AmoMax, AmoMin};

    adder_a = {{2{do_sext & old_i[DataWidth-1]}}, old_i};
    adder_b = {{2{do_sext & operand_i[DataWidth-1]}}, operand_i};
    // Subtract as a + ~b + 1
    if (do_sub) begin
      adder_b = ~adder_b;
    end
  end

  assign adder_sum = adder_a + adder_b + {{(DataWidth+1){1'b0}}, do_sub};
  // Negative difference means old word below operand
  assign old_lt    = adder_sum[DataWidth+1];

  // ------------------------------
  // Result select
  // ------------------------------
  always_comb begin
    unique case (op_i)
      AmoSwap: result_o = operand_i;
      AmoAdd:  result_o = adder_sum[DataWidth-1:0];
      AmoAnd:  result_o = old_i & operand_i;
      AmoOr:   result_o = old_i | operand_i;
      AmoXor:  result_o = old_i ^ operand_i;
      AmoMax,
      AmoMaxu: result_o = old_lt ? operand_i : old_i;
      AmoMin,
      AmoMinu: result_o = old_lt ? old_i : operand_i;
      default: result_o = old_i;
    endcase
  end

endmodule

/* rtl/amo_pkg.sv */
// Atomic opcodes and adapter states.
// Codes 10 to 15 exist on the bus but are not atomics here;
// such requests behave as plain loads or stores.
package amo_pkg;

  // ------------------------------
  // Atomic opcodes
  // ------------------------------
  // Encoding as seen on the request amo field
  typedef enum logic [3:0] {
    AmoNone = 4'h0,
    AmoSwap = 4'h1,
    AmoAdd  = 4'h2,
    AmoAnd  = 4'h3,
    AmoOr   = 4'h4,
    AmoXor  = 4'h5,
    AmoMax  = 4'h6,
    AmoMaxu = 4'h7,
    AmoMin  = 4'h8,
    AmoMinu = 4'h9
  } amo_op_e;

  // ------------------------------
  // Adapter FSM
  // ------------------------------
  // Idle serves loads, stores and the read half of an atomic
  // DoAmo owns the SRAM port for the write-back cycle
  typedef enum logic {
    Idle,
    DoAmo
  } adapter_state_e;

endpackage

/* rtl/sram_bank.sv */
// Single-ported word SRAM model, BankWords deep.
// Byte-enabled writes; reads return data one cycle after the request.
// Read data holds its value across writes and idle cycles.
// Contents are undefined after power-up.
`timescale 1ns/1ps

module sram_bank
  import tcdm_pkg::*;
(
  input  logic     clk_i,
  input  mem_req_t mem_i,
  output data_t    rdata_o
);

  data_t mem_q [BankWords];
  data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (mem_i.req) begin
      if (mem_i.write) begin
        // Merge only the enabled bytes
        for (int unsigned b = 0; b < BeWidth; b++) begin
          if (mem_i.be[b]) begin
            mem_q[mem_i.idx][b*8 +: 8] <= mem_i.wdata[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[mem_i.idx];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* rtl/tcdm_bank_top.sv */
// TCDM bank with valid/ready adapter and atomic support.
// The adapter has exclusive access to the SRAM behind it.
// Loads and atomics respond in order, earliest one cycle after
// acceptance; stores give no response.
`timescale 1ns/1ps

module tcdm_bank_top
  import tcdm_pkg::*;
  import amo_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // Request stream
  input  logic      in_valid_i,
  input  tcdm_req_t req_i,
  output logic      in_ready_o,
  // Response stream
  output logic      out_valid_o,
  input  logic      out_ready_i,
  output tcdm_rsp_t rsp_o
);

  mem_req_t mem_req;
  data_t    sram_rdata;
  logic     meta_push;
  logic     rdata_push;
  logic     resp_pending;
  amo_op_e  amo_op;
  data_t    amo_operand;
  data_t    amo_result;

  // ------------------------------
  // Decode and sequencing
  // ------------------------------
  tcdm_req_decode req_decode_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .in_valid_i     (in_valid_i),
    .req_i          (req_i),
    .in_ready_o     (in_ready_o),
    .resp_pending_i (resp_pending),
    .out_ready_i    (out_ready_i),
    .mem_o          (mem_req),
    .meta_push_o    (meta_push),
    .rdata_push_o   (rdata_push),
    .amo_op_o       (amo_op),
    .amo_operand_o  (amo_operand),
    .amo_result_i   (amo_result)
  );

  // Old word comes straight from the SRAM read port
  amo_alu amo_alu_inst (
    .op_i      (amo_op),
    .old_i     (sram_rdata),
    .operand_i (amo_operand),
    .result_o  (amo_result)
  );

  // ------------------------------
  // Response path and memory
  // ------------------------------
  tcdm_resp_buffer resp_buffer_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .meta_push_i  (meta_push),
    .meta_i       (req_i.meta),
    .rdata_push_i (rdata_push),
    .rdata_i      (sram_rdata),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .rsp_o        (rsp_o),
    .pending_o    (resp_pending)
  );

  sram_bank sram_bank_inst (
    .clk_i   (clk_i),
    .mem_i   (mem_req),
    .rdata_o (sram_rdata)
  );

endmodule

/* rtl/tcdm_pkg.sv */
// Widths and bus types shared by the TCDM bank and its adapter.
// One bank of BankWords 32-bit words, word-addressed by address bits 9..2.
// Address bits above the bank index are ignored by the bank.
package tcdm_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned BeWidth      = DataWidth / 8;
  localparam int unsigned MetaWidth    = 8;
  localparam int unsigned AmoWidth     = 4;
  localparam int unsigned BankWords    = 256;
  localparam int unsigned BankIdxWidth = $clog2(BankWords);
  // Byte offset within a word, skipped when indexing the bank
  localparam int unsigned ByteOffWidth = $clog2(BeWidth);

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [BeWidth-1:0]      be_t;
  typedef logic [MetaWidth-1:0]    meta_t;
  typedef logic [AmoWidth-1:0]     amo_code_t;
  typedef logic [BankIdxWidth-1:0] bank_idx_t;

  // ------------------------------
  // Bus structs
  // ------------------------------
  // Request from the requester, raw atomic code as sent on the bus
  typedef struct packed {
    addr_t     addr;
    amo_code_t amo;
    logic      write;
    data_t     wdata;
    be_t       be;
    meta_t     meta;
  } tcdm_req_t;

  // Load or AMO response, meta is echoed back unchanged
  typedef struct packed {
    data_t rdata;
    meta_t meta;
  } tcdm_rsp_t;

  // Single-cycle SRAM command
  typedef struct packed {
    logic      req;
    logic      write;
    bank_idx_t idx;
    data_t     wdata;
    be_t       be;
  } mem_req_t;

endpackage

/* rtl/tcdm_req_decode.sv */
// Request decode and sequencing for the bank adapter.
// Idle forwards an accepted request to the SRAM in the same cycle.
// An atomic reads in Idle and writes back one cycle later in DoAmo,
// with new requests blocked for that cycle.
// New requests are also held off while a response waits unconsumed.
`timescale 1ns/1ps

module tcdm_req_decode
  import tcdm_pkg::*;
  import amo_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // Request stream
  input  logic      in_valid_i,
  input  tcdm_req_t req_i,
  output logic      in_ready_o,
  // Response side status
  input  logic      resp_pending_i,
  input  logic      out_ready_i,
  // SRAM port
  output mem_req_t  mem_o,
  // Response bookkeeping
  output logic      meta_push_o,
  output logic      rdata_push_o,
  // AMO ALU
  output amo_op_e   amo_op_o,
  output data_t     amo_operand_o,
  input  data_t     amo_result_i
);

  adapter_state_e state_q, state_d;

  // Saved atomic, used during the write-back cycle
  amo_op_e   amo_op_q;
  bank_idx_t amo_idx_q;
  data_t     amo_operand_q;

  // Read data shows up one cycle after the SRAM read
  logic rdata_push_q;

  logic      req_accepted;
  logic      is_amo;
  logic      is_read;
  amo_op_e   req_op;
  bank_idx_t req_idx;

  // ------------------------------
  // Request classification
  // ------------------------------
  assign req_op  = amo_op_e'(req_i.amo);
  // Only swap through minu count as atomics
  assign is_amo  = req_op inside {[AmoSwap:AmoMinu]};
  // An atomic always reads first, regardless of the write flag
  assign is_read = is_amo | ~req_i.write;
  assign req_idx = req_i.addr[ByteOffWidth +: BankIdxWidth];

  // Blocked in DoAmo and while a response sits untaken
  assign in_ready_o   = (state_q == Idle) & ~(resp_pending_i & ~out_ready_i);
  assign req_accepted = in_valid_i & in_ready_o;

  // Meta goes in at acceptance, read data follows a cycle later
  assign meta_push_o  = req_accepted & is_read;
  assign rdata_push_o = rdata_push_q;

  assign amo_op_o      = amo_op_q;
  assign amo_operand_o = amo_operand_q;

  // ------------------------------
  // SRAM command and FSM
  // ------------------------------
  always_comb begin
    state_d = state_q;

    // Default is a straight feed-through of the request
    mem_o.req   = req_accepted;
    mem_o.write = req_i.write & ~is_amo;
    mem_o.idx   = req_idx;
    mem_o.wdata = req_i.wdata;
    mem_o.be    = req_i.be;

    unique case (state_q)
      Idle: begin
        if (req_accepted && is_amo) begin
          state_d = DoAmo;
        end
      end
      DoAmo: begin
        // Full-word write of the ALU result at the saved index
        mem_o.req   = 1'b1;
        mem_o.write = 1'b1;
        mem_o.idx   = amo_idx_q;
        mem_o.wdata = amo_result_i;
        mem_o.be    = '1;
        state_d     = Idle;
      end
    endcase
  end

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Idle;
      rdata_push_q <= 1'b0;
      amo_op_q     <= AmoNone;
    end else begin
      state_q      <= state_d;
      rdata_push_q <= req_accepted & is_read;
      if (req_accepted && is_amo) begin
        amo_op_q <= req_op;
      end
    end
  end

  // Atomic address and operand
  always_ff @(posedge clk_i) begin
    if (req_accepted && is_amo) begin
      amo_idx_q     <= req_idx;
      amo_operand_q <= req_i.wdata;
    end
  end

endmodule

/* rtl/tcdm_resp_buffer.sv */
// Response buffer for loads and atomics.
// Metadata is pushed at acceptance into a two-entry queue; read data
// arrives a cycle later into a one-entry fall-through stage.
// A response is valid when both have an entry; both pop on handshake.
// Pushing into a full queue or stage is not guarded; the adapter's
// ready logic prevents it.
`timescale 1ns/1ps

module tcdm_resp_buffer
  import tcdm_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // Metadata at acceptance
  input  logic      meta_push_i,
  input  meta_t     meta_i,
  // Read data one cycle later
  input  logic      rdata_push_i,
  input  data_t     rdata_i,
  // Response stream
  output logic      out_valid_o,
  input  logic      out_ready_i,
  output tcdm_rsp_t rsp_o,
  // Holding an undelivered response
  output logic      pending_o
);

  // ------------------------------
  // Metadata queue
  // ------------------------------
  meta_t      meta_q [2];
  logic       meta_wr_q;
  logic       meta_rd_q;
  logic [1:0] meta_cnt_q;

  // ------------------------------
  // Read-data stage
  // ------------------------------
  data_t data_q;
  logic  data_valid_q;

  logic data_avail;
  logic pop;
  logic store_in;

  // Incoming data falls straight through when the stage is empty
  assign data_avail = data_valid_q | rdata_push_i;
  assign out_valid_o = data_avail & (meta_cnt_q != 2'd0);
  assign pop         = out_valid_o & out_ready_i;
  assign pending_o   = out_valid_o;

  assign rsp_o.rdata = data_valid_q ? data_q : rdata_i;
  assign rsp_o.meta  = meta_q[meta_rd_q];

  // Keep incoming data unless it is consumed in this very cycle
  assign store_in = rdata_push_i & (data_valid_q | ~pop);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      meta_wr_q    <= 1'b0;
      meta_rd_q    <= 1'b0;
      meta_cnt_q   <= 2'd0;
      data_valid_q <= 1'b0;
    end else begin
      if (meta_push_i) begin
        meta_wr_q <= ~meta_wr_q;
      end
      if (pop) begin
        meta_rd_q <= ~meta_rd_q;
      end
      // Count moves only when push and pop differ
      if (meta_push_i && !pop) begin
        meta_cnt_q <= meta_cnt_q + 2'd1;
      end else if (!meta_push_i && pop) begin
        meta_cnt_q <= meta_cnt_q - 2'd1;
      end
      data_valid_q <= (data_valid_q & ~pop) | store_in;
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (meta_push_i) begin
      meta_q[meta_wr_q] <= meta_i;
    end
    if (store_in) begin
      data_q <= rdata_i;
    end
  end

endmodule

/* verilog.f */
rtl/tcdm_pkg.sv
rtl/amo_pkg.sv
rtl/sram_bank.sv
rtl/amo_alu.sv
rtl/tcdm_resp_buffer.sv
rtl/tcdm_req_decode.sv
rtl/tcdm_bank_top.sv
dv/tcdm_bank_checker.sv
dv/tb_tcdm_bank.sv
